// File: filelist.f
+incdir+verilog
verilog/calc_data_pkg.sv
verilog/calc_ctrl_pkg.sv
verilog/arith_if.sv
verilog/add_sub_unit.sv
verilog/shift_add_multiplier.sv
verilog/calc_controller.sv
verilog/calc_top.sv
testbench/calc_chk.sv
testbench/calc_monitor.sv
testbench/calc_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build calc_tb with Verilator, run it and scan the log for a failure

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f filelist.f --top-module calc_tb -o calc_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

./obj_dir/calc_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "TEST FAIL" "$LOG"; then
    echo "Simulation reported a failure"
    exit 1
fi

echo "Simulation finished without failures"
exit 0

// File: testbench/calc_tb.sv
`timescale 1ns/10ps
`include "calc_settings.svh"

module calc_tb;

    localparam int WAIT_LIMIT = 200;    // Cycles before any wait gives up

    logic clk;
    logic nRST;
    logic [`CALC_DIGIT_W-1:0] keypad_input;
    logic read_input;
    logic [2:0] operator_input;
    logic equal_input;
    logic ready;
    logic complete;
    calc_data_pkg::word_t display_output;

    int test_id;
    calc_data_pkg::word_t expected;
    int pass_count;
    int fail_count;

    // Stimulus table with one entry per calculation
    string row_a[$];                    // Operand 1 digits
    logic [2:0] row_op[$];
    string row_b[$];                    // Operand 2 digits
    logic [2:0] row_bad[$];             // Invalid operator after the first digit or 0 for none
    bit row_noise[$];                   // Keys pressed while scaling is busy
    calc_data_pkg::word_t row_exp[$];

    int seed;
    int row;
    bit ok;
    bit aborted;

    calc_top i_dut (
        .clk            (clk),
        .nRST           (nRST),
        .keypad_input   (keypad_input),
        .read_input     (read_input),
        .operator_input (operator_input),
        .equal_input    (equal_input),
        .ready          (ready),
        .complete       (complete),
        .display_output (display_output)
    );

    calc_monitor i_monitor (
        .clk            (clk),
        .nRST           (nRST),
        .complete       (complete),
        .display_output (display_output),
        .test_id        (test_id),
        .expected       (expected),
        .pass_count     (pass_count),
        .fail_count     (fail_count)
    );

    bind calc_controller calc_chk i_chk (
        .clk        (clk),
        .nRST       (nRST),
        .ready      (ready),
        .complete   (complete),
        .alu_start  (alu.start),
        .alu_finish (alu.finish),
        .mul_start  (mul.start),
        .mul_finish (mul.finish)
    );

    always #20 clk = ~clk;

    task automatic add_row(input string a, input logic [2:0] op, input string b,
                           input logic [2:0] bad, input bit noise,
                           input calc_data_pkg::word_t result);
        row_a.push_back(a);
        row_op.push_back(op);
        row_b.push_back(b);
        row_bad.push_back(bad);
        row_noise.push_back(noise);
        row_exp.push_back(result);
    endtask

    // ASCII digits carry their value in the low nibble
    function automatic logic [`CALC_DIGIT_W-1:0] digit_of(input byte c);
        return c[`CALC_DIGIT_W-1:0];
    endfunction

    // Times ten plus digit with wrap at the word width
    function automatic calc_data_pkg::word_t entry_value(input string digits);
        calc_data_pkg::word_t v;
        int i;
        v = '0;
        for (i = 0; i < digits.len(); i++) begin
            v = calc_data_pkg::word_t'(v * 10 + digit_of(digits[i]));
        end
        return v;
    endfunction

    function automatic calc_data_pkg::word_t expected_result(input logic [2:0] op,
                                                             input calc_data_pkg::word_t a,
                                                             input calc_data_pkg::word_t b);
        calc_data_pkg::word_t r;
        case (op)
            calc_data_pkg::OP_ADD: r = a + b;
            calc_data_pkg::OP_SUB: r = a - b;   // Wraps below zero
            default:               r = a * b;   // Low word of the product
        endcase
        return r;
    endfunction

    task automatic wait_ready(output bit done);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (ready !== 1'b1 && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        done = (ready === 1'b1);
        if (!done) begin
            $display("Timeout: ready stayed low for %0d cycles in test %0d", WAIT_LIMIT, test_id);
        end
    endtask

    task automatic wait_complete(output bit done);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (complete !== 1'b1 && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        done = (complete === 1'b1);
        if (!done) begin
            $display("Timeout: no complete pulse within %0d cycles in test %0d",
                     WAIT_LIMIT, test_id);
        end
    endtask

    // One key for one cycle once the DUT is ready
    task automatic press_key(input logic [`CALC_DIGIT_W-1:0] digit, input bit rd,
                             input logic [2:0] op, input bit eq, output bit done);
        wait_ready(done);
        if (!done) return;
        @(posedge clk);
        keypad_input   <= digit;
        read_input     <= rd;
        operator_input <= op;
        equal_input    <= eq;
        @(posedge clk);
        read_input     <= 1'b0;
        operator_input <= '0;
        equal_input    <= 1'b0;
    endtask

    // Every key at once while the multiplier scales
    task automatic press_while_busy();
        @(posedge clk);
        keypad_input   <= 4'd9;
        read_input     <= 1'b1;
        operator_input <= calc_data_pkg::OP_MUL;
        equal_input    <= 1'b1;
        repeat (2) @(posedge clk);
        read_input     <= 1'b0;
        operator_input <= '0;
        equal_input    <= 1'b0;
    endtask

    task automatic enter_operand(input string digits, input logic [2:0] bad,
                                 input bit noise, output bit done);
        int i;
        done = 1'b1;
        for (i = 0; i < digits.len(); i++) begin
            press_key(digit_of(digits[i]), 1'b1, 3'b000, 1'b0, done);
            if (!done) return;
            if (noise) press_while_busy();
            if (i == 0 && bad != 3'b000) begin
                press_key('0, 1'b0, bad, 1'b0, done);
                if (!done) return;
            end
        end
    endtask

    task automatic run_row(input int n, output bit done);
        @(posedge clk);
        test_id  <= n + 1;
        expected <= row_exp[n];
        enter_operand(row_a[n], row_bad[n], row_noise[n], done);
        if (!done) return;
        press_key('0, 1'b0, row_op[n], 1'b0, done);
        if (!done) return;
        enter_operand(row_b[n], 3'b000, row_noise[n], done);
        if (!done) return;
        press_key('0, 1'b0, 3'b000, 1'b1, done);
        if (!done) return;
        wait_complete(done);
    endtask

    initial begin
        int a_val;
        int b_val;
        int pick;
        logic [2:0] op;
        string a_str;
        string b_str;

        clk            = 1'b0;
        nRST           = 1'b0;
        keypad_input   = '0;
        read_input     = 1'b0;
        operator_input = '0;
        equal_input    = 1'b0;
        test_id        = 0;
        expected       = '0;
        aborted        = 1'b0;
        seed           = 32'hcf86;

        add_row("123",   calc_data_pkg::OP_ADD, "0",     3'b000, 1'b0, 16'd123);
        add_row("65535", calc_data_pkg::OP_ADD, "2",     3'b000, 1'b0, 16'd1);
        add_row("5",     calc_data_pkg::OP_SUB, "7",     3'b000, 1'b0, 16'd65534);
        add_row("300",   calc_data_pkg::OP_MUL, "300",   3'b000, 1'b0, 16'd24464);
        add_row("12",    calc_data_pkg::OP_MUL, "12",    3'b000, 1'b0, 16'd144);
        add_row("12",    calc_data_pkg::OP_ADD, "5",     3'b011, 1'b0, 16'd17);
        add_row("45",    calc_data_pkg::OP_SUB, "40",    3'b110, 1'b0, 16'd5);
        add_row("7",     calc_data_pkg::OP_MUL, "6",     3'b000, 1'b1, 16'd42);
        add_row("100",   calc_data_pkg::OP_SUB, "1",     3'b000, 1'b1, 16'd99);
        add_row("70000", calc_data_pkg::OP_ADD, "0",     3'b000, 1'b0, 16'd4464);
        add_row("0",     calc_data_pkg::OP_MUL, "65535", 3'b000, 1'b0, 16'd0);

        repeat (6) begin
            a_val = $unsigned($random(seed)) % 100000;
            b_val = $unsigned($random(seed)) % 100000;
            pick  = $unsigned($random(seed)) % 3;
            op    = 3'b001 << pick;
            a_str = $sformatf("%0d", a_val);
            b_str = $sformatf("%0d", b_val);
            add_row(a_str, op, b_str, 3'b000, 1'b0,
                    expected_result(op, entry_value(a_str), entry_value(b_str)));
        end

        repeat (4) @(posedge clk);
        nRST <= 1'b1;

        for (row = 0; row < row_a.size() && !aborted; row++) begin
            run_row(row, ok);
            if (!ok) aborted = 1'b1;
        end

        repeat (2) @(posedge clk);
        @(negedge clk);
        $display("Checks passed: %0d, failed: %0d", pass_count, fail_count);
        if (!aborted && fail_count == 0 && pass_count == row_a.size() + 1) begin
            $display("TEST PASS");
        end else begin
            if (!aborted && fail_count == 0) begin
                $display("Checked %0d results where %0d were expected",
                         pass_count, row_a.size() + 1);
            end
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// File: testbench/calc_monitor.sv
`timescale 1ns/10ps
`include "calc_settings.svh"

module calc_monitor (
    input  logic clk,
    input  logic nRST,
    input  logic complete,
    input  calc_data_pkg::word_t display_output,
    input  int test_id,                         // Calculation now running
    input  calc_data_pkg::word_t expected,      // Its expected display value
    output int pass_count,
    output int fail_count
);

    logic reset_checked;    // Reset values already looked at

    always @(posedge clk) begin
        if (!nRST) begin
            reset_checked <= 1'b0;
            pass_count    <= 0;
            fail_count    <= 0;
        end else if (!reset_checked) begin
            // First cycle out of reset
            reset_checked <= 1'b1;
            if (complete !== 1'b0 || display_output !== '0) begin
                $display("ERROR at %0t: after reset complete=%b display=%0d, expected 0 and 0",
                         $time, complete, display_output);
                fail_count <= fail_count + 1;
            end else begin
                $display("Test 0 passed: complete and display are zero after reset");
                pass_count <= pass_count + 1;
            end
        end else if (complete === 1'b1) begin
            if (display_output !== expected) begin
                $display("ERROR at %0t: test %0d display %0d, expected %0d",
                         $time, test_id, display_output, expected);
                fail_count <= fail_count + 1;
            end else begin
                $display("Test %0d passed: display %0d", test_id, display_output);
                pass_count <= pass_count + 1;
            end
        end
    end

endmodule

// File: testbench/calc_chk.sv
`timescale 1ns/10ps

module calc_chk (
    input logic clk,
    input logic nRST,
    input logic ready,
    input logic complete,
    input logic alu_start,
    input logic alu_finish,
    input logic mul_start,
    input logic mul_finish
);

    logic alu_busy;     // Between start and finish of the adder
    logic mul_busy;     // Between start and finish of the multiplier

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            alu_busy <= 1'b0;
            mul_busy <= 1'b0;
        end else begin
            if (alu_start) begin
                alu_busy <= 1'b1;
            end else if (alu_finish) begin
                alu_busy <= 1'b0;
            end
            if (mul_start) begin
                mul_busy <= 1'b1;
            end else if (mul_finish) begin
                mul_busy <= 1'b0;
            end
        end
    end

    alu_start_pulse: assert property (@(posedge clk) disable iff (!nRST)
        alu_start |=> !alu_start) else $error("alu start longer than one cycle");

    mul_start_pulse: assert property (@(posedge clk) disable iff (!nRST)
        mul_start |=> !mul_start) else $error("mul start longer than one cycle");

    ready_while_busy: assert property (@(posedge clk) disable iff (!nRST)
        !(ready && (alu_busy || mul_busy))) else $error("ready high while a unit is busy");

    complete_pulse: assert property (@(posedge clk) disable iff (!nRST)
        complete |=> !complete) else $error("complete longer than one cycle");

endmodule

// File: verilog/calc_top.sv
`timescale 1ns/10ps
`include "calc_settings.svh"

module calc_top (
    input  logic clk,
    input  logic nRST,
    input  logic [`CALC_DIGIT_W-1:0] keypad_input,
    input  logic read_input,
    input  logic [2:0] operator_input,
    input  logic equal_input,
    output logic ready,
    output logic complete,
    output logic [`CALC_WIDTH-1:0] display_output
);

    arith_if alu_bus ();    // Controller to adder/subtractor
    arith_if mul_bus ();    // Controller to multiplier

    calc_controller i_controller (
        .clk            (clk),
        .nRST           (nRST),
        .keypad_input   (keypad_input),
        .read_input     (read_input),
        .operator_input (operator_input),
        .equal_input    (equal_input),
        .ready          (ready),
        .complete       (complete),
        .display_output (display_output),
        .alu            (alu_bus.controller),
        .mul            (mul_bus.controller)
    );

    add_sub_unit i_add_sub (
        .clk  (clk),
        .nRST (nRST),
        .bus  (alu_bus.unit)
    );

    // Shared between digit scaling and the multiply key
    shift_add_multiplier i_mul (
        .clk  (clk),
        .nRST (nRST),
        .bus  (mul_bus.unit)
    );

endmodule

// File: verilog/calc_controller.sv
`timescale 1ns/10ps
`include "calc_settings.svh"

module calc_controller (
    input  logic clk,
    input  logic nRST,

    input  logic [`CALC_DIGIT_W-1:0] keypad_input,  // One decimal digit
    input  logic read_input,                        // Take the digit on keypad_input
    input  logic [2:0] operator_input,              // One-hot operator key
    input  logic equal_input,                       // Run the calculation

    output logic ready,                             // Keys are accepted
    output logic complete,                          // Result just loaded
    output calc_data_pkg::word_t display_output,

    arith_if.controller alu,
    arith_if.controller mul
);

    calc_ctrl_pkg::ctrl_state_t state;

    calc_data_pkg::word_t operand1;
    calc_data_pkg::word_t operand2;
    calc_data_pkg::op_t op_latched;

    logic [`CALC_DIGIT_W-1:0] digit;    // Digit waiting for the scaled operand
    logic scale_op2;                    // Scaling belongs to operand 2

    logic op_valid;
    logic unit_finish;
    calc_data_pkg::word_t unit_result;
    calc_data_pkg::word_t scaled;

    assign op_valid = operator_input inside {calc_data_pkg::OP_ADD,
                                             calc_data_pkg::OP_SUB,
                                             calc_data_pkg::OP_MUL};

    // Handshake of whichever unit the operator picked
    assign unit_finish = (op_latched == calc_data_pkg::OP_MUL) ? mul.finish : alu.finish;
    assign unit_result = (op_latched == calc_data_pkg::OP_MUL) ? mul.out : alu.out;

    // Operand times ten plus the new digit
    assign scaled = mul.out + {{(`CALC_WIDTH - `CALC_DIGIT_W){1'b0}}, digit};

    assign ready = (state == calc_ctrl_pkg::ENTER_OP1) ||
                   (state == calc_ctrl_pkg::ENTER_OP2);
    assign complete = (state == calc_ctrl_pkg::SHOW_RESULT);

    assign mul.sub = 1'b0;      // Multiplier has no subtract

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            state          <= calc_ctrl_pkg::ENTER_OP1;
            operand1       <= '0;
            operand2       <= '0;
            op_latched     <= calc_data_pkg::OP_ADD;
            scale_op2      <= 1'b0;
            display_output <= '0;
            alu.start      <= 1'b0;
            mul.start      <= 1'b0;
        end else begin
            alu.start <= 1'b0;      // Starts last one cycle
            mul.start <= 1'b0;
            case (state)
                calc_ctrl_pkg::ENTER_OP1: begin
                    if (read_input) begin
                        mul.start <= 1'b1;
                        scale_op2 <= 1'b0;
                        state     <= calc_ctrl_pkg::SCALE_WAIT;
                    end else if (op_valid) begin
                        op_latched <= calc_data_pkg::op_t'(operator_input);
                        state      <= calc_ctrl_pkg::ENTER_OP2;
                    end
                end
                calc_ctrl_pkg::ENTER_OP2: begin
                    if (read_input) begin
                        mul.start <= 1'b1;
                        scale_op2 <= 1'b1;
                        state     <= calc_ctrl_pkg::SCALE_WAIT;
                    end else if (equal_input) begin
                        state <= calc_ctrl_pkg::CALC_DISPATCH;
                    end
                end
                calc_ctrl_pkg::SCALE_WAIT: begin
                    if (mul.finish) begin
                        if (scale_op2) begin
                            operand2 <= scaled;
                            state    <= calc_ctrl_pkg::ENTER_OP2;
                        end else begin
                            operand1 <= scaled;
                            state    <= calc_ctrl_pkg::ENTER_OP1;
                        end
                    end
                end
                calc_ctrl_pkg::CALC_DISPATCH: begin
                    if (op_latched == calc_data_pkg::OP_MUL) begin
                        mul.start <= 1'b1;
                    end else begin
                        alu.start <= 1'b1;
                    end
                    state <= calc_ctrl_pkg::CALC_WAIT;
                end
                calc_ctrl_pkg::CALC_WAIT: begin
                    if (unit_finish) begin
                        display_output <= unit_result;
                        state          <= calc_ctrl_pkg::SHOW_RESULT;
                    end
                end
                calc_ctrl_pkg::SHOW_RESULT: begin
                    operand1 <= '0;     // Next calculation starts fresh
                    operand2 <= '0;
                    state    <= calc_ctrl_pkg::ENTER_OP1;
                end
                default: state <= calc_ctrl_pkg::ENTER_OP1;
            endcase
        end
    end

    // Operands for the units, loaded on the edge that raises start
    always_ff @(posedge clk) begin
        case (state)
            calc_ctrl_pkg::ENTER_OP1, calc_ctrl_pkg::ENTER_OP2: begin
                if (read_input) begin
                    digit   <= keypad_input;
                    mul.in1 <= (state == calc_ctrl_pkg::ENTER_OP2) ? operand2 : operand1;
                    mul.in2 <= calc_data_pkg::word_t'(10);
                end
            end
            calc_ctrl_pkg::CALC_DISPATCH: begin
                alu.in1 <= operand1;
                alu.in2 <= operand2;
                alu.sub <= (op_latched == calc_data_pkg::OP_SUB);
                mul.in1 <= operand1;
                mul.in2 <= operand2;
            end
            default: ;
        endcase
    end

endmodule

// File: verilog/shift_add_multiplier.sv
`timescale 1ns/10ps
`include "calc_settings.svh"

module shift_add_multiplier (
    input logic clk,
    input logic nRST,
    arith_if.unit bus
);

    // Steps left in the current product, zero when idle
    logic [$clog2(`CALC_MUL_STEPS + 1)-1:0] step_count;

    calc_data_pkg::word_t mcand;    // Multiplicand, shifts left
    calc_data_pkg::word_t mplier;   // Multiplier, shifts right
    calc_data_pkg::word_t acc;      // Partial product, low bits only

    logic busy;

    assign busy = (step_count != '0);

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            step_count <= '0;
            bus.finish <= 1'b0;
        end else begin
            bus.finish <= 1'b0;
            if (bus.start) begin
                step_count <= `CALC_MUL_STEPS;
            end else if (busy) begin
                step_count <= step_count - 1'b1;
                // Last step lands this edge, so finish shows with the final sum
                if (step_count == 1) begin
                    bus.finish <= 1'b1;
                end
            end
        end
    end

    // One multiplier bit per cycle
    always_ff @(posedge clk) begin
        if (bus.start) begin
            mcand  <= bus.in1;
            mplier <= bus.in2;
            acc    <= '0;
        end else if (busy) begin
            if (mplier[0]) begin
                acc <= acc + mcand;     // Overflow past the word is dropped
            end
            mcand  <= mcand << 1;
            mplier <= mplier >> 1;
        end
    end

    assign bus.out = acc;

endmodule

// File: verilog/add_sub_unit.sv
`timescale 1ns/10ps

module add_sub_unit (
    input logic clk,
    input logic nRST,
    arith_if.unit bus
);

    calc_data_pkg::word_t result;

    // Answer arrives one cycle after the request
    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            bus.finish <= 1'b0;
        end else begin
            bus.finish <= bus.start;
        end
    end

    // Result register holds until the next start
    always_ff @(posedge clk) begin
        if (bus.start) begin
            if (bus.sub) begin
                result <= bus.in1 - bus.in2;    // Wraps below zero
            end else begin
                result <= bus.in1 + bus.in2;    // Carry out dropped
            end
        end
    end

    assign bus.out = result;

endmodule

// File: verilog/arith_if.sv
`timescale 1ns/10ps

interface arith_if;

    calc_data_pkg::word_t in1;      // First operand
    calc_data_pkg::word_t in2;      // Second operand
    logic sub;                      // Subtract instead of add
    logic start;                    // One-cycle request
    calc_data_pkg::word_t out;      // Result, valid with finish
    logic finish;                   // One-cycle completion

    modport controller (
        output in1, in2, sub, start,
        input  out, finish
    );

    modport unit (
        input  in1, in2, sub, start,
        output out, finish
    );

endinterface

// File: verilog/calc_ctrl_pkg.sv
package calc_ctrl_pkg;

    // Controller FSM states
    typedef enum logic [2:0] {
        ENTER_OP1     = 3'd0,   // Digits go to operand 1
        ENTER_OP2     = 3'd1,   // Digits go to operand 2
        SCALE_WAIT    = 3'd2,   // Multiplier doing operand times ten
        CALC_DISPATCH = 3'd3,   // Start the selected unit
        CALC_WAIT     = 3'd4,   // Wait for that unit to finish
        SHOW_RESULT   = 3'd5    // Result on display, complete high
    } ctrl_state_t;

endpackage

// File: verilog/calc_data_pkg.sv
`include "calc_settings.svh"

package calc_data_pkg;

    // One operand or result, all arithmetic wraps at this width
    typedef logic [`CALC_WIDTH-1:0] word_t;

    // Operator keys are one-hot on the keypad
    typedef enum logic [2:0] {
        OP_ADD = 3'b001,    // Addition
        OP_SUB = 3'b010,    // Subtraction, wraps below zero
        OP_MUL = 3'b100     // Multiplication, low word kept
    } op_t;

endpackage

// File: verilog/calc_settings.svh
`ifndef CALC_SETTINGS_SVH
`define CALC_SETTINGS_SVH

// Operand, result and display width
`define CALC_WIDTH 16

// One decimal digit from the keypad
`define CALC_DIGIT_W 4

// One multiplier iteration per multiplier bit
`define CALC_MUL_STEPS `CALC_WIDTH

`endif
